/* rtl/grid_pkg.sv */
`default_nettype none

package grid_pkg;

    // fixed word widths of the resource-grid path
    typedef logic [15:0] iq_t;
    typedef logic [7:0]  blk_exp_t;
    typedef logic [9:0]  sfn_t;
    typedef logic [4:0]  subframe_t;
    typedef logic [3:0]  symbol_t;
    typedef logic [63:0] sample_id_t;

    // a 64-bit timestamp goes out as four IQ-sized words
    localparam int TS_WORDS = $bits(sample_id_t) / $bits(iq_t);

    typedef logic [$clog2(TS_WORDS)-1:0] ts_idx_t;

    // sideband field from the FFT stage, spare bit in the lsb
    typedef struct packed {
        sfn_t      sfn;
        subframe_t subframe;
        symbol_t   symbol;
        blk_exp_t  blk_exp;
        logic      spare;
    } grid_user_t;

    // input word and IQ FIFO entry
    typedef struct packed {
        iq_t        iq;
        logic       last;
        grid_user_t user;
    } iq_beat_t;

    // word towards the DMA
    typedef struct packed {
        iq_t  data;
        logic last;
    } out_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        TIMESTAMP,
        TS_TAIL,
        FORWARD
    } framer_state_e;

endpackage

`default_nettype wire

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 4
) (
    input  wire logic             clk_i,
    input  wire logic             reset_ni,
    input  wire logic             wr_valid_i,
    input  wire logic [WIDTH-1:0] wr_data_i,
    input  wire logic             rd_ready_i,
    output logic                  rd_valid_o,
    output logic      [WIDTH-1:0] rd_data_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [CW-1:0]    count_q;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full  = (count_q == CW'(DEPTH));
    // a write into a full buffer is lost
    assign wr_en = wr_valid_i && !full;
    assign rd_en = rd_ready_i && rd_valid_o;

    // first word fall-through, head is always on the output
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                // pointers wrap at DEPTH, so any depth works
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/symbol_timestamper.sv */
`timescale 1ns/1ps
`default_nettype none

module symbol_timestamper (
    input  wire logic        clk_i,
    input  wire logic        reset_ni,
    input  wire logic        in_valid_i,
    input  wire logic        in_last_i,
    output logic             ts_valid_o,
    output grid_pkg::sample_id_t ts_o
);

    import grid_pkg::*;

    sample_id_t sample_cnt_q;
    // high while waiting for the first sample of a symbol
    logic       sos_q;

    // count before this strobe is the number of earlier samples
    assign ts_valid_o = in_valid_i && sos_q;
    assign ts_o       = sample_cnt_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt_q <= '0;
            sos_q        <= 1'b1;
        end else if (in_valid_i) begin
            sample_cnt_q <= sample_cnt_q + 1'b1;
            // next strobe after a last one opens a new symbol
            sos_q        <= in_last_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/grid_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module grid_framer (
    input  wire logic                 clk_i,
    input  wire logic                 reset_ni,
    // IQ FIFO head
    input  wire logic                 iq_valid_i,
    input  wire grid_pkg::iq_beat_t   iq_head_i,
    output logic                      iq_pop_o,
    // timestamp FIFO head
    input  wire logic                 ts_valid_i,
    input  wire grid_pkg::sample_id_t ts_i,
    output logic                      ts_pop_o,
    // towards the DMA
    input  wire logic                 out_ready_i,
    output logic                      out_valid_o,
    output grid_pkg::out_beat_t       out_beat_o,
    output logic                      overflow_o,
    output logic                      irq_o
);

    import grid_pkg::*;

    localparam ts_idx_t TS_LAST_IDX = ts_idx_t'(TS_WORDS - 1);

    framer_state_e state_q;
    framer_state_e state_d;
    ts_idx_t       ts_cnt_q;
    ts_idx_t       ts_cnt_d;
    sample_id_t    ts_buf_q;
    sample_id_t    ts_buf_d;
    iq_t           data_q;
    iq_t           data_d;
    logic          valid_q;
    logic          valid_d;
    logic          last_q;
    logic          last_d;
    logic          irq_q;
    logic          overflow_q;

    // pops only take effect when the FIFO shows a word
    assign ts_pop_o = (state_q == TIMESTAMP);
    assign iq_pop_o = (state_q == FORWARD);

    always_comb begin
        state_d  = state_q;
        ts_cnt_d = ts_cnt_q;
        ts_buf_d = ts_buf_q;
        data_d   = data_q;
        valid_d  = 1'b0;
        last_d   = 1'b0;
        case (state_q)
            IDLE: begin
                // head word stays in the FIFO, only its exponent is read here
                if (iq_valid_i) begin
                    data_d  = iq_t'(iq_head_i.user.blk_exp);
                    valid_d = 1'b1;
                    state_d = TIMESTAMP;
                end
            end
            TIMESTAMP: begin
                if (ts_valid_i) begin
                    data_d   = iq_t'(ts_i);
                    ts_buf_d = ts_i >> $bits(iq_t);
                    ts_cnt_d = '0;
                    valid_d  = 1'b1;
                    state_d  = TS_TAIL;
                end
            end
            TS_TAIL: begin
                ts_cnt_d = ts_cnt_q + 1'b1;
                if (ts_cnt_q == TS_LAST_IDX) begin
                    // one empty cycle before the IQ words
                    state_d = FORWARD;
                end else begin
                    data_d   = iq_t'(ts_buf_q);
                    ts_buf_d = ts_buf_q >> $bits(iq_t);
                    valid_d  = 1'b1;
                end
            end
            FORWARD: begin
                data_d  = iq_head_i.iq;
                valid_d = iq_valid_i;
                last_d  = iq_valid_i && iq_head_i.last;
                if (last_d) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= IDLE;
            ts_cnt_q   <= '0;
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
            irq_q      <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            ts_cnt_q   <= ts_cnt_d;
            valid_q    <= valid_d;
            last_q     <= last_d;
            irq_q      <= last_d;
            // the output never stalls, a refused beat is only flagged
            overflow_q <= valid_q && !out_ready_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q   <= data_d;
        ts_buf_q <= ts_buf_d;
    end

    assign out_valid_o     = valid_q;
    assign out_beat_o.data = data_q;
    assign out_beat_o.last = last_q;
    assign overflow_o      = overflow_q;
    assign irq_o           = irq_q;

endmodule

`default_nettype wire

/* rtl/grid_framer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module grid_framer_top #(
    parameter int IQ_FIFO_DEPTH = 1024,
    parameter int TS_FIFO_DEPTH = 4
) (
    input  wire logic               clk_i,
    input  wire logic               reset_ni,
    input  wire logic               in_valid_i,
    input  wire grid_pkg::iq_beat_t in_beat_i,
    input  wire logic               out_ready_i,
    output logic                    out_valid_o,
    output grid_pkg::out_beat_t     out_beat_o,
    output logic                    overflow_o,
    output logic                    irq_o
);

    import grid_pkg::*;

    iq_beat_t   iq_head;
    logic       iq_valid;
    logic       iq_pop;
    logic       ts_wr_valid;
    sample_id_t ts_wr_data;
    sample_id_t ts_head;
    logic       ts_valid;
    logic       ts_pop;

    symbol_timestamper i_symbol_timestamper (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_valid_i (in_valid_i),
        .in_last_i  (in_beat_i.last),
        .ts_valid_o (ts_wr_valid),
        .ts_o       (ts_wr_data)
    );

    // whole input beat is buffered, user field included
    sync_fifo #(
        .WIDTH ($bits(iq_beat_t)),
        .DEPTH (IQ_FIFO_DEPTH)
    ) iq_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_valid_i (in_valid_i),
        .wr_data_i  (in_beat_i),
        .rd_ready_i (iq_pop),
        .rd_valid_o (iq_valid),
        .rd_data_o  (iq_head)
    );

    sync_fifo #(
        .WIDTH ($bits(sample_id_t)),
        .DEPTH (TS_FIFO_DEPTH)
    ) ts_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_valid_i (ts_wr_valid),
        .wr_data_i  (ts_wr_data),
        .rd_ready_i (ts_pop),
        .rd_valid_o (ts_valid),
        .rd_data_o  (ts_head)
    );

    grid_framer i_grid_framer (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .iq_valid_i  (iq_valid),
        .iq_head_i   (iq_head),
        .iq_pop_o    (iq_pop),
        .ts_valid_i  (ts_valid),
        .ts_i        (ts_head),
        .ts_pop_o    (ts_pop),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_beat_o  (out_beat_o),
        .overflow_o  (overflow_o),
        .irq_o       (irq_o)
    );

endmodule

`default_nettype wire

/* testbench/grid_framer_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module grid_framer_sva (
    input wire logic                clk_i,
    input wire logic                reset_ni,
    input wire logic                out_ready_i,
    input wire logic                out_valid_o,
    input wire grid_pkg::out_beat_t out_beat_o,
    input wire logic                overflow_o,
    input wire logic                irq_o
);

    last_implies_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_beat_o.last |-> out_valid_o)
        else $error("last flag without a valid beat");

    irq_on_last_beat: assert property (@(posedge clk_i) disable iff (!reset_ni)
        irq_o == (out_valid_o && out_beat_o.last))
        else $error("irq does not match the last valid beat");

    // a refused beat is flagged one cycle later
    overflow_after_refusal: assert property (@(posedge clk_i) disable iff (!reset_ni)
        overflow_o == $past(out_valid_o && !out_ready_i))
        else $error("overflow does not follow a refused beat");

    quiet_in_reset: assert property (@(posedge clk_i)
        !reset_ni |=> !out_valid_o)
        else $error("output valid while in reset");

endmodule

bind grid_framer_top grid_framer_sva i_grid_framer_sva (.*);

`default_nettype wire

/* testbench/tb_grid_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_grid_framer;

    import grid_pkg::*;

    localparam int TOTAL_SAMPLES  = 12 + 8 + 20 + 5 + 16 + 11 + 24;
    localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 4 + 2000;

    logic        clk_i = 1'b0;
    logic        reset_ni;
    logic        in_valid_i;
    iq_beat_t    in_beat_i;
    logic        out_ready_i;
    logic        out_valid_o;
    out_beat_t   out_beat_o;
    logic        overflow_o;
    logic        irq_o;

    int          errors;
    int          irq_cnt;
    int          ovf_cnt;
    logic [15:0] lfsr_state;
    sample_id_t  model_cnt;
    out_beat_t   exp_q[$];
    out_beat_t   mon_exp;
    logic        mon_irq;
    logic        prev_valid;
    logic        prev_ready;

    grid_framer_top #(
        .IQ_FIFO_DEPTH (64),
        .TS_FIFO_DEPTH (4)
    ) i_grid_framer_top (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_valid_i  (in_valid_i),
        .in_beat_i   (in_beat_i),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_beat_o  (out_beat_o),
        .overflow_o  (overflow_o),
        .irq_o       (irq_o)
    );

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    // Fibonacci taps of x^16 + x^14 + x^13 + x^11 + 1
    // one shift per returned bit
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[14:0], fb};
        end
        return r;
    endfunction

    task automatic check_beat(input out_beat_t act, input out_beat_t exp, input string what);
        if (act !== exp) begin
            $display("error at %0t: %s got data %h last %b, expected data %h last %b",
                     $time, what, act.data, act.last, exp.data, exp.last);
            errors++;
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, act, exp);
            errors++;
        end
    endtask

    // registered outputs have settled by the falling edge
    always @(negedge clk_i) begin
        if (!reset_ni) begin
            check_flag(out_valid_o, 1'b0, "out_valid_o in reset");
            prev_valid = 1'b0;
            prev_ready = 1'b0;
        end else begin
            mon_irq = 1'b0;
            check_flag(overflow_o, prev_valid && !prev_ready, "overflow_o");
            if (out_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("output beat %h arrived with nothing expected", out_beat_o.data);
                    errors++;
                end else begin
                    mon_exp = exp_q.pop_front();
                    mon_irq = mon_exp.last;
                    check_beat(out_beat_o, mon_exp, "output beat");
                end
            end else begin
                check_flag(out_beat_o.last, 1'b0, "last flag without valid");
            end
            check_flag(irq_o, mon_irq, "irq_o");
            if (irq_o) begin
                irq_cnt++;
            end
            if (overflow_o) begin
                ovf_cnt++;
            end
            prev_valid = out_valid_o;
            prev_ready = out_ready_i;
        end
    end

    // model gets the header words before the IQ words of the symbol
    task automatic send_symbol(input int len, input blk_exp_t bexp);
        iq_beat_t  b;
        out_beat_t e;
        e.data = iq_t'(bexp);
        e.last = 1'b0;
        exp_q.push_back(e);
        for (int i = 0; i < TS_WORDS; i++) begin
            e.data = iq_t'(model_cnt >> ($bits(iq_t) * i));
            exp_q.push_back(e);
        end
        for (int i = 0; i < len; i++) begin
            b.iq            = lfsr_bits(16);
            b.last          = (i == len - 1);
            b.user.sfn      = sfn_t'(lfsr_bits(10));
            b.user.subframe = subframe_t'(lfsr_bits(5));
            b.user.symbol   = symbol_t'(lfsr_bits(4));
            b.user.blk_exp  = bexp;
            b.user.spare    = 1'(lfsr_bits(1));
            @(posedge clk_i);
            in_valid_i <= 1'b1;
            in_beat_i  <= b;
            e.data = b.iq;
            e.last = b.last;
            exp_q.push_back(e);
        end
        model_cnt += len;
    endtask

    task automatic idle_input();
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic wait_drain(input int n_sym, input int irq_base);
        int limit;
        int waited;
        // a few cycles per outstanding beat is ample
        limit  = exp_q.size() * 4 + 50;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(posedge clk_i);
            waited++;
        end
        repeat (4) @(posedge clk_i);
        if (irq_cnt - irq_base != n_sym) begin
            $display("error at %0t: %0d irq pulses, expected %0d", $time,
                     irq_cnt - irq_base, n_sym);
            errors++;
        end
    endtask

    task automatic check_reset_idle();
        repeat (8) begin
            @(negedge clk_i);
            check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
            check_flag(out_beat_o.last, 1'b0, "last after reset");
            check_flag(overflow_o, 1'b0, "overflow_o after reset");
            check_flag(irq_o, 1'b0, "irq_o after reset");
        end
    endtask

    task automatic single_symbol_test();
        int base;
        base = irq_cnt;
        send_symbol(12, 8'h05);
        idle_input();
        wait_drain(1, base);
    endtask

    // user fields change on every beat and only blk_exp may reach the output
    task automatic back_to_back_test();
        int lens[5];
        int base;
        lens = '{8, 20, 5, 16, 11};
        base = irq_cnt;
        foreach (lens[i]) begin
            send_symbol(lens[i], blk_exp_t'(lfsr_bits(8)));
        end
        idle_input();
        wait_drain(5, base);
    endtask

    task automatic ready_gaps_test();
        int base;
        base = irq_cnt;
        fork
            begin
                send_symbol(24, blk_exp_t'(lfsr_bits(8)));
                idle_input();
            end
            begin
                for (int k = 0; k < 40; k++) begin
                    @(posedge clk_i);
                    // refuse two cycles out of every five
                    out_ready_i <= !((k % 5) == 1 || (k % 5) == 2);
                end
                @(posedge clk_i);
                out_ready_i <= 1'b1;
            end
        join
        wait_drain(1, base);
        if (ovf_cnt == 0) begin
            $display("overflow_o never rose while the DMA refused beats");
            errors++;
        end
    endtask

    initial begin
        errors      = 0;
        irq_cnt     = 0;
        ovf_cnt     = 0;
        lfsr_state  = 16'd16;
        model_cnt   = '0;
        prev_valid  = 1'b0;
        prev_ready  = 1'b0;
        reset_ni    = 1'b0;
        in_valid_i  = 1'b0;
        in_beat_i   = '0;
        out_ready_i = 1'b1;
        repeat (10) @(posedge clk_i);
        reset_ni <= 1'b1;
        check_reset_idle();
        single_symbol_test();
        back_to_back_test();
        ready_gaps_test();
        if (exp_q.size() != 0) begin
            $display("%0d expected beats never came out", exp_q.size());
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/grid_pkg.sv
rtl/sync_fifo.sv
rtl/symbol_timestamper.sv
rtl/grid_framer.sv
rtl/grid_framer_top.sv
testbench/grid_framer_sva.sv
testbench/tb_grid_framer.sv
